// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - alu_pkg.sv
  - divider.sv
  - bit_count_unit.sv
  - alu.sv
  - branch_resolver.sv
  - exec_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exec_stage.sv

// ==== alu.sv ====
`timescale 1ns/1ps

module alu import alu_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            valid_i,
    input  alu_op_e         op_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    output logic [XLEN-1:0] result_o,
    output logic            done_o,
    output cmp_flags_t      flags_o
);

    logic [CTR_BITS-1:0]      cnt_q;
    logic                     started_q;

    logic                     first;
    logic                     is_div;
    logic                     is_cnt;
    logic                     div_zero;
    logic                     use_div;
    div_op_e                  div_op;
    count_op_e                cnt_op;
    logic                     div_start;
    logic [XLEN-1:0]          div_result;
    logic                     div_done;
    logic                     cnt_start;
    logic [XLEN-1:0]          cnt_result;
    logic                     cnt_done;

    logic [XLEN-1:0]          add_a;
    logic [XLEN-1:0]          add_b;
    logic [XLEN-1:0]          sum;
    logic [SHAMT_BITS-1:0]    shamt;
    logic signed [2*XLEN-1:0] product;
    logic [XLEN-1:0]          rev;

    always_comb begin
        is_div = 1'b0;
        is_cnt = 1'b0;
        div_op = DIVOP_DIV;
        cnt_op = CNT_CPOP;
        case (op_i)
            ALU_DIV:     begin is_div = 1'b1; div_op = DIVOP_DIV;  end
            ALU_DIVU:    begin is_div = 1'b1; div_op = DIVOP_DIVU; end
            ALU_REM:     begin is_div = 1'b1; div_op = DIVOP_REM;  end
            ALU_REMU:    begin is_div = 1'b1; div_op = DIVOP_REMU; end
            ALU_HAMMING: begin is_cnt = 1'b1; cnt_op = CNT_HAMMING; end
            ALU_CTZ:     begin is_cnt = 1'b1; cnt_op = CNT_CTZ;     end
            ALU_CPOP:    begin is_cnt = 1'b1; cnt_op = CNT_CPOP;    end
            default:     ;
        endcase
    end

    // quotient by zero is all ones, no divider run
    assign div_zero  = ((op_i == ALU_DIV) || (op_i == ALU_DIVU)) && (rs2_i == '0);
    assign use_div   = is_div && !div_zero;
    assign first     = (cnt_q == '0) && !started_q;
    assign div_start = valid_i && use_div && first;
    assign cnt_start = valid_i && is_cnt && first;

    // shared adder for add, sub and shift-left-add
    assign add_a   = (op_i == ALU_SHADD) ? {rs1_i[XLEN-2:0], 1'b0} : rs1_i;
    assign add_b   = (op_i == ALU_SUB) ? (~rs2_i + 1'b1) : rs2_i;
    assign sum     = add_a + add_b;
    assign shamt   = rs2_i[SHAMT_BITS-1:0];
    assign product = $signed(rs1_i) * $signed(rs2_i);

    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            rev[i] = rs1_i[XLEN-1-i];
        end
    end

    assign flags_o = '{eq: (rs1_i == rs2_i),
                       lt: ($signed(rs1_i) < $signed(rs2_i)),
                       ltu: (rs1_i < rs2_i)};

    always_comb begin
        case (op_i)
            ALU_ADD, ALU_SUB, ALU_SHADD:      result_o = sum;
            ALU_AND:                          result_o = rs1_i & rs2_i;
            ALU_OR:                           result_o = rs1_i | rs2_i;
            ALU_XOR:                          result_o = rs1_i ^ rs2_i;
            ALU_SLL:                          result_o = rs1_i << shamt;
            ALU_SRL:                          result_o = rs1_i >> shamt;
            ALU_SRA:                          result_o = $signed(rs1_i) >>> shamt;
            ALU_SLT:                          result_o = XLEN'(flags_o.lt);
            ALU_SLTU:                         result_o = XLEN'(flags_o.ltu);
            ALU_MUL:                          result_o = product[XLEN-1:0];
            ALU_MULH:                         result_o = product[2*XLEN-1:XLEN];
            ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU:
                                              result_o = div_zero ? '1 : div_result;
            ALU_PACK:  result_o = {rs2_i[XLEN/2 +: XLEN/2], rs1_i[0 +: XLEN/2]};
            ALU_REV:                          result_o = rev;
            ALU_HAMMING, ALU_CTZ, ALU_CPOP:   result_o = cnt_result;
            default:                          result_o = '0;
        endcase
    end

    always_comb begin
        if (use_div) begin
            done_o = valid_i && started_q && div_done;
        end else if (is_cnt) begin
            done_o = valid_i && started_q && cnt_done;
        end else begin
            done_o = valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i || !valid_i || done_o) begin
            cnt_q     <= '0;
            started_q <= 1'b0;
        end else begin
            if (cnt_q != '1) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (div_start || cnt_start) begin
                started_q <= 1'b1;
            end
        end
    end

    divider divider_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (div_start),
        .op_i       (div_op),
        .dividend_i (rs1_i),
        .divisor_i  (rs2_i),
        .result_o   (div_result),
        .done_o     (div_done)
    );

    bit_count_unit bit_count_unit_i (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .start_i (cnt_start),
        .op_i    (cnt_op),
        .a_i     (rs1_i),
        .b_i     (rs2_i),
        .count_o (cnt_result),
        .done_o  (cnt_done)
    );

    // op held by the issuer for the whole request
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_i && !done_o |=> $stable(op_i));

endmodule

// ==== alu_pkg.sv ====
package alu_pkg;

    localparam int XLEN        = 32;
    localparam int SHAMT_BITS  = 5;
    localparam int COUNT_STEP  = 8;
    localparam int COUNT_STEPS = XLEN / COUNT_STEP;
    localparam int CTR_BITS    = 6;

    // fall-through pc increment and link offset
    localparam logic [XLEN-1:0] PC_STEP = 4;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_MUL,
        ALU_MULH,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU,
        ALU_PACK,
        ALU_REV,
        ALU_SHADD,
        ALU_HAMMING,
        ALU_CTZ,
        ALU_CPOP
    } alu_op_e;

    typedef enum logic [4:0] {
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } branch_op_e;

    typedef enum logic [1:0] {
        DIVOP_DIV,
        DIVOP_DIVU,
        DIVOP_REM,
        DIVOP_REMU
    } div_op_e;

    typedef enum logic [1:0] {
        CNT_HAMMING,
        CNT_CTZ,
        CNT_CPOP
    } count_op_e;

    // same five bits, meaning picked by is_branch
    typedef union packed {
        alu_op_e    alu;
        branch_op_e br;
    } exec_func_u;

    typedef struct packed {
        logic            valid;
        logic            is_branch;
        exec_func_u      func;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
    } exec_req_t;

    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } cmp_flags_t;

    typedef struct packed {
        logic            done;
        logic [XLEN-1:0] data;
        logic            taken;
        logic [XLEN-1:0] target;
    } exec_rsp_t;

endpackage

// ==== bit_count_unit.sv ====
`timescale 1ns/1ps

module bit_count_unit import alu_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            start_i,
    input  count_op_e       op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] count_o,
    output logic            done_o
);

    logic                  busy_q;
    logic [CTR_BITS-1:0]   step_q;
    logic                  seen_q;
    logic [XLEN-1:0]       acc_q;

    logic                  load;
    logic [XLEN-1:0]       src;
    logic [COUNT_STEP-1:0] slice;
    logic [CTR_BITS-1:0]   slice_cnt;
    logic                  seen_d;

    assign load  = start_i && !busy_q;
    assign src   = (op_i == CNT_HAMMING) ? (a_i ^ b_i) : a_i;
    assign slice = COUNT_STEP'(src >> (step_q * COUNT_STEP));

    // count of the current slice, ctz stops at the first one
    always_comb begin
        slice_cnt = '0;
        seen_d    = seen_q;
        for (int i = 0; i < COUNT_STEP; i++) begin
            if (op_i == CNT_CTZ) begin
                if (!seen_d && !slice[i]) begin
                    slice_cnt = slice_cnt + 1'b1;
                end
                if (slice[i]) begin
                    seen_d = 1'b1;
                end
            end else begin
                slice_cnt = slice_cnt + CTR_BITS'(slice[i]);
            end
        end
    end

    assign done_o  = busy_q && (step_q == CTR_BITS'(COUNT_STEPS));
    assign count_o = acc_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            step_q <= '0;
            seen_q <= 1'b0;
        end else if (load) begin
            busy_q <= 1'b1;
            step_q <= '0;
            seen_q <= 1'b0;
        end else if (done_o) begin
            busy_q <= 1'b0;
            step_q <= '0;
        end else if (busy_q) begin
            step_q <= step_q + 1'b1;
            seen_q <= seen_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            acc_q <= '0;
        end else if (busy_q && !done_o) begin
            acc_q <= acc_q + XLEN'(slice_cnt);
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        step_q <= CTR_BITS'(COUNT_STEPS));

endmodule

// ==== branch_resolver.sv ====
`timescale 1ns/1ps

module branch_resolver import alu_pkg::*; (
    input  branch_op_e      op_i,
    input  cmp_flags_t      flags_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] imm_i,
    output logic            taken_o,
    output logic [XLEN-1:0] target_o
);

    logic [XLEN-1:0] offset;

    always_comb begin
        case (op_i)
            BR_BEQ:  taken_o = flags_i.eq;
            BR_BNE:  taken_o = !flags_i.eq;
            BR_BLT:  taken_o = flags_i.lt;
            BR_BGE:  taken_o = !flags_i.lt;
            BR_BLTU: taken_o = flags_i.ltu;
            BR_BGEU: taken_o = !flags_i.ltu;
            default: taken_o = 1'b0;
        endcase
    end

    // not taken falls through to the next instruction
    assign offset   = taken_o ? imm_i : PC_STEP;
    assign target_o = pc_i + offset;

endmodule

// ==== divider.sv ====
`timescale 1ns/1ps

module divider import alu_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            start_i,
    input  div_op_e         op_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic [XLEN-1:0] result_o,
    output logic            done_o
);

    logic                busy_q;
    logic                fin_q;
    logic [CTR_BITS-1:0] step_q;
    div_op_e             op_q;
    logic                neg_quot_q;
    logic                neg_rem_q;
    logic [XLEN-1:0]     divisor_q;
    logic [XLEN-1:0]     quot_q;
    logic [XLEN-1:0]     rem_q;

    logic                is_signed;
    logic                neg_a;
    logic                neg_b;
    logic [XLEN-1:0]     abs_a;
    logic [XLEN-1:0]     abs_b;
    logic [XLEN:0]       partial;
    logic                fits;
    logic                load;
    logic [XLEN-1:0]     quot_fix;
    logic [XLEN-1:0]     rem_fix;

    assign is_signed = (op_i == DIVOP_DIV) || (op_i == DIVOP_REM);
    assign neg_a     = is_signed && dividend_i[XLEN-1];
    assign neg_b     = is_signed && divisor_i[XLEN-1];
    assign abs_a     = neg_a ? (~dividend_i + 1'b1) : dividend_i;
    assign abs_b     = neg_b ? (~divisor_i + 1'b1) : divisor_i;
    assign load      = start_i && !busy_q;

    // bring down the next dividend bit and try the subtract
    assign partial = {rem_q, quot_q[XLEN-1]};
    assign fits    = partial >= {1'b0, divisor_q};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            fin_q  <= 1'b0;
            step_q <= '0;
        end else begin
            fin_q <= 1'b0;
            if (load) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == CTR_BITS'(XLEN - 1)) begin
                    busy_q <= 1'b0;
                    fin_q  <= 1'b1;
                    step_q <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            op_q       <= op_i;
            neg_quot_q <= neg_a ^ neg_b;
            neg_rem_q  <= neg_a;
            divisor_q  <= abs_b;
            quot_q     <= abs_a;
            rem_q      <= '0;
        end else if (busy_q) begin
            rem_q  <= fits ? (partial[XLEN-1:0] - divisor_q) : partial[XLEN-1:0];
            quot_q <= {quot_q[XLEN-2:0], fits};
        end
    end

    // remainder follows the dividend sign
    assign quot_fix = neg_quot_q ? (~quot_q + 1'b1) : quot_q;
    assign rem_fix  = neg_rem_q ? (~rem_q + 1'b1) : rem_q;

    assign result_o = ((op_q == DIVOP_DIV) || (op_q == DIVOP_DIVU)) ? quot_fix : rem_fix;
    assign done_o   = fin_q;

    // one start per request, never into a running division
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        start_i |-> !(busy_q || fin_q));

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage import alu_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  exec_req_t req_i,
    output exec_rsp_t rsp_o
);

    logic            alu_valid;
    logic [XLEN-1:0] alu_result;
    logic            alu_done;
    cmp_flags_t      flags;
    logic            br_taken;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] link;

    assign alu_valid = req_i.valid && !req_i.is_branch;
    assign link      = req_i.pc + PC_STEP;

    alu alu_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .valid_i  (alu_valid),
        .op_i     (req_i.func.alu),
        .rs1_i    (req_i.rs1),
        .rs2_i    (req_i.rs2),
        .result_o (alu_result),
        .done_o   (alu_done),
        .flags_o  (flags)
    );

    branch_resolver branch_resolver_i (
        .op_i     (req_i.func.br),
        .flags_i  (flags),
        .pc_i     (req_i.pc),
        .imm_i    (req_i.imm),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    // branches resolve in the request cycle
    always_comb begin
        rsp_o.done   = req_i.is_branch ? req_i.valid : alu_done;
        rsp_o.data   = req_i.is_branch ? link : alu_result;
        rsp_o.taken  = req_i.is_branch && br_taken;
        rsp_o.target = br_target;
    end

endmodule

// ==== tb_exec_checks.svh ====
// typed compare tasks, request driver and test bookkeeping

task automatic check_data(input string what, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s data %h, expected %h", $time, what, got, exp);
        error_count++;
    end
endtask

task automatic check_branch(input string what, input exec_rsp_t got,
                            input logic exp_taken, input logic [XLEN-1:0] exp_target);
    if (got.taken !== exp_taken || got.target !== exp_target) begin
        $display("** Error at %0t: %s taken %b target %h, expected taken %b target %h",
                 $time, what, got.taken, got.target, exp_taken, exp_target);
        error_count++;
    end
endtask

task automatic check_latency(input string what, input int got, input int lo, input int hi);
    if (got < lo || got > hi) begin
        $display("** Error at %0t: %s done after %0d cycles, expected %0d to %0d",
                 $time, what, got, lo, hi);
        error_count++;
    end
endtask

// present a request on the next edge and wait for its done
task automatic run_request(input string what, input exec_req_t r,
                           output exec_rsp_t got, output int cycles);
    @(posedge clk);
    req <= r;
    cycles = 0;
    @(negedge clk);
    while (!rsp.done && cycles < DONE_LIMIT) begin
        cycles++;
        @(negedge clk);
    end
    got = rsp;
    if (!rsp.done) begin
        $display("%s: done never arrived within %0d cycles, at time %0t",
                 what, DONE_LIMIT, $time);
        error_count++;
    end
endtask

task automatic idle();
    @(posedge clk);
    req <= '0;
endtask

task automatic start_test();
    test_errors_at_start = error_count;
endtask

task automatic finish_test(input string name);
    if (error_count == test_errors_at_start) begin
        $display("test %s: ok", name);
        tests_passed++;
    end else begin
        $display("test %s: %0d errors", name, error_count - test_errors_at_start);
        tests_failed++;
    end
endtask

// ==== tb_exec_stage.sv ====
`timescale 1ns/1ps

module tb_exec_stage import alu_pkg::*; ();

    localparam int DONE_LIMIT     = 2 * XLEN;
    // about twice the cycles that all tests together need
    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic      clk;
    logic      rstn;
    exec_req_t req;
    exec_rsp_t rsp;
    int        cycle_count;
    int        error_count;
    int        test_errors_at_start;
    int        tests_passed;
    int        tests_failed;

    exec_stage exec_stage_i (
        .clk_i  (clk),
        .rstn_i (rstn),
        .req_i  (req),
        .rsp_o  (rsp)
    );

    `include "tb_exec_checks.svh"

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, tests did not finish", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic exec_req_t alu_req(alu_op_e op, logic [XLEN-1:0] a,
                                          logic [XLEN-1:0] b);
        exec_req_t r;
        r          = '0;
        r.valid    = 1'b1;
        r.func.alu = op;
        r.rs1      = a;
        r.rs2      = b;
        return r;
    endfunction

    function automatic exec_req_t branch_req(branch_op_e op, logic [XLEN-1:0] a,
                                             logic [XLEN-1:0] b, logic [XLEN-1:0] pc,
                                             logic [XLEN-1:0] imm);
        exec_req_t r;
        r           = '0;
        r.valid     = 1'b1;
        r.is_branch = 1'b1;
        r.func.br   = op;
        r.rs1       = a;
        r.rs2       = b;
        r.pc        = pc;
        r.imm       = imm;
        return r;
    endfunction

    function automatic logic [XLEN-1:0] reverse_bits(logic [XLEN-1:0] a);
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++) begin
            r[XLEN-1-i] = a[i];
        end
        return r;
    endfunction

    function automatic int ones_in(logic [XLEN-1:0] a);
        int n;
        n = 0;
        for (int i = 0; i < XLEN; i++) begin
            n += a[i];
        end
        return n;
    endfunction

    function automatic int trailing_zeros(logic [XLEN-1:0] a);
        int n;
        n = 0;
        while (n < XLEN && !a[n]) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic [XLEN-1:0] expected_single(alu_op_e op, logic [XLEN-1:0] a,
                                                        logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] p;
        p = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_AND:   return a & b;
            ALU_OR:    return a | b;
            ALU_XOR:   return a ^ b;
            ALU_SLL:   return a << b[4:0];
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return $signed(a) >>> b[4:0];
            ALU_SLT:   return ($signed(a) < $signed(b)) ? 1 : 0;
            ALU_SLTU:  return (a < b) ? 1 : 0;
            ALU_MUL:   return p[XLEN-1:0];
            ALU_MULH:  return p[2*XLEN-1:XLEN];
            ALU_PACK:  return {b[XLEN-1:XLEN/2], a[XLEN/2-1:0]};
            ALU_REV:   return reverse_bits(a);
            ALU_SHADD: return (a << 1) + b;
            default:   return '0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expected_div(alu_op_e op, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        if (b == '0) begin
            return (op == ALU_DIV || op == ALU_DIVU) ? '1 : a;
        end
        // signed overflow case
        if ((op == ALU_DIV || op == ALU_REM) && a == MOST_NEG && b == '1) begin
            return (op == ALU_DIV) ? a : '0;
        end
        case (op)
            ALU_DIV:  return $signed(a) / $signed(b);
            ALU_REM:  return $signed(a) % $signed(b);
            ALU_DIVU: return a / b;
            default:  return a % b;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expected_count(alu_op_e op, logic [XLEN-1:0] a,
                                                       logic [XLEN-1:0] b);
        case (op)
            ALU_HAMMING: return ones_in(a ^ b);
            ALU_CTZ:     return trailing_zeros(a);
            default:     return ones_in(a);
        endcase
    endfunction

    function automatic logic branch_taken(branch_op_e op, logic [XLEN-1:0] a,
                                          logic [XLEN-1:0] b);
        case (op)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic single_cycle_arith();
        alu_op_e ops [15] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
                              ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PACK, ALU_REV,
                              ALU_SHADD, ALU_MUL, ALU_MULH};
        alu_op_e         op;
        exec_req_t       r;
        exec_rsp_t       got;
        int              cycles;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        start_test();
        for (int i = 0; i < 15; i++) begin
            op = ops[i];
            for (int k = 0; k < 4; k++) begin
                a = $urandom;
                b = $urandom;
                r = alu_req(op, a, b);
                run_request(op.name(), r, got, cycles);
                check_data(op.name(), got.data, expected_single(op, a, b));
                check_latency(op.name(), cycles, 0, 0);
            end
        end
        idle();
        finish_test("single-cycle arithmetic");
    endtask

    task automatic divide_and_remainder();
        alu_op_e ops [4] = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
        alu_op_e         op;
        exec_req_t       r;
        exec_rsp_t       got;
        int              cycles;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        start_test();
        for (int i = 0; i < 4; i++) begin
            op = ops[i];
            for (int k = 0; k < 4; k++) begin
                a = $urandom;
                b = $urandom >> ($urandom % 28);
                if (b == '0) begin
                    b = 5;
                end
                run_request(op.name(), alu_req(op, a, b), got, cycles);
                check_data(op.name(), got.data, expected_div(op, a, b));
                check_latency(op.name(), cycles, XLEN, DONE_LIMIT);
            end
            // divide by zero
            a = $urandom;
            run_request("by zero", alu_req(op, a, '0), got, cycles);
            check_data("by zero", got.data, expected_div(op, a, '0));
            if (op == ALU_DIV || op == ALU_DIVU) begin
                check_latency("div by zero", cycles, 0, 0);
            end
            run_request("most negative by -1", alu_req(op, MOST_NEG, '1), got, cycles);
            check_data("most negative by -1", got.data, expected_div(op, MOST_NEG, '1));
        end
        idle();
        finish_test("division");
    endtask

    task automatic bit_count_ops();
        alu_op_e ops [3] = '{ALU_CPOP, ALU_HAMMING, ALU_CTZ};
        logic [XLEN-1:0] vals [6];
        alu_op_e         op;
        exec_rsp_t       got;
        int              cycles;
        logic [XLEN-1:0] b;
        start_test();
        for (int i = 0; i < 3; i++) begin
            op      = ops[i];
            vals[0] = $urandom;
            vals[1] = $urandom;
            vals[2] = $urandom;
            vals[3] = '0;
            vals[4] = '1;
            vals[5] = MOST_NEG;
            for (int k = 0; k < 6; k++) begin
                b = $urandom;
                run_request(op.name(), alu_req(op, vals[k], b), got, cycles);
                check_data(op.name(), got.data, expected_count(op, vals[k], b));
                check_latency(op.name(), cycles, COUNT_STEPS + 1, COUNT_STEPS + 1);
            end
        end
        idle();
        finish_test("bit counts");
    endtask

    task automatic branch_conditions();
        branch_op_e ops [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        logic [XLEN-1:0] as [3];
        logic [XLEN-1:0] bs [3];
        branch_op_e      op;
        exec_rsp_t       got;
        int              cycles;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic            taken;
        start_test();
        as[0] = $urandom;
        bs[0] = as[0];
        // lower signed but higher unsigned, then the reverse
        as[1] = 32'hffff_fff0;
        bs[1] = 32'h0000_0010;
        as[2] = 32'h0000_0010;
        bs[2] = 32'hffff_fff0;
        for (int i = 0; i < 6; i++) begin
            op = ops[i];
            for (int k = 0; k < 3; k++) begin
                pc    = $urandom & 32'hffff_fffc;
                imm   = $urandom & 32'hffff_fffe;
                taken = branch_taken(op, as[k], bs[k]);
                run_request(op.name(), branch_req(op, as[k], bs[k], pc, imm), got, cycles);
                check_branch(op.name(), got, taken, taken ? pc + imm : pc + 4);
                check_data(op.name(), got.data, pc + 4);
                check_latency(op.name(), cycles, 0, 0);
            end
        end
        idle();
        finish_test("branches");
    endtask

    task automatic back_to_back_requests();
        exec_rsp_t       got;
        int              cycles;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        start_test();
        a = $urandom;
        run_request("cpop", alu_req(ALU_CPOP, a, '0), got, cycles);
        check_data("cpop", got.data, expected_count(ALU_CPOP, a, '0));
        check_latency("cpop", cycles, COUNT_STEPS + 1, COUNT_STEPS + 1);
        a = $urandom;
        b = ($urandom >> 8) | 1;
        run_request("div after cpop", alu_req(ALU_DIV, a, b), got, cycles);
        check_data("div after cpop", got.data, expected_div(ALU_DIV, a, b));
        check_latency("div after cpop", cycles, XLEN, DONE_LIMIT);
        a = $urandom;
        b = $urandom;
        run_request("add after div", alu_req(ALU_ADD, a, b), got, cycles);
        check_data("add after div", got.data, a + b);
        check_latency("add after div", cycles, 0, 0);
        idle();
        finish_test("back-to-back");
    endtask

    task automatic reset_mid_divide();
        exec_req_t r;
        exec_rsp_t got;
        int        cycles;
        start_test();
        @(posedge clk);
        req <= alu_req(ALU_DIVU, 32'd1000000, 32'd7);
        repeat (8) @(posedge clk);
        rstn <= 1'b0;
        req  <= '0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        // issued while the aborted divide would still be running
        // -100 rem 7
        r = alu_req(ALU_REM, 32'hffff_ff9c, 32'd7);
        run_request("rem after reset", r, got, cycles);
        check_data("rem after reset", got.data, expected_div(ALU_REM, r.rs1, r.rs2));
        check_latency("rem after reset", cycles, XLEN, DONE_LIMIT);
        idle();
        finish_test("reset mid divide");
    endtask

    initial begin
        void'($urandom(36806));
        rstn <= 1'b0;
        req  <= '0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        single_cycle_arith();
        divide_and_remainder();
        bit_count_ops();
        branch_conditions();
        back_to_back_requests();
        reset_mid_divide();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
alu_pkg.sv
divider.sv
bit_count_unit.sv
alu.sv
branch_resolver.sv
exec_stage.sv
tb_exec_stage.sv
